/* Makefile */
all: run

obj_dir/Vmove_gen_tb: move_gen_top.f $(wildcard logic/*.sv dv/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module move_gen_tb \
		-f move_gen_top.f -o Vmove_gen_tb

run: obj_dir/Vmove_gen_tb
	obj_dir/Vmove_gen_tb

lint:
	verilator --lint-only -Wall --timing --top-module move_gen_tb -f move_gen_top.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

/* dv/move_gen_assert.sv */
`timescale 1ns/10ps

module move_gen_assert #(
   parameter int MAX_MOVES = 128
) (
   input logic                 clk,
   input logic                 reset,
   input logic                 moves_ready,
   input logic                 clear_moves,
   input chess_pkg::move_idx_t move_count
);

   // level held until the user clears
   ready_held: assert property (@(posedge clk) disable iff (reset)
      moves_ready && !clear_moves |=> moves_ready)
      else $error("moves_ready fell before clear_moves was seen");

   count_steady: assert property (@(posedge clk) disable iff (reset)
      moves_ready |=> !moves_ready || $stable(move_count))
      else $error("move_count changed while moves_ready was high");

   count_bound: assert property (@(posedge clk) disable iff (reset)
      move_count <= MAX_MOVES)
      else $error("move_count is above the store depth");

endmodule

bind move_gen_top move_gen_assert #(
   .MAX_MOVES (MAX_MOVES)
) u_move_gen_assert (
   .clk         (clk),
   .reset       (reset),
   .moves_ready (moves_ready),
   .clear_moves (clear_moves),
   .move_count  (move_count)
);

/* dv/move_gen_tb.sv */
`timescale 1ns/10ps

module move_gen_tb;
   import chess_pkg::*;

   logic      clk;
   logic      reset;
   logic      board_valid;
   board_t    board_in;
   logic      white_to_move_in;
   logic      clear_moves;
   move_idx_t move_index;
   logic      moves_ready;
   move_idx_t move_count;
   board_t    board_out;

   // one entry per B line
   board_t    test_board [$];
   logic      test_white [$];
   move_idx_t test_count [$];
   int        test_first [$]; // first M entry of the test
   int        test_picks [$];

   // one entry per M line
   move_idx_t pick_index [$];
   board_t    pick_board [$];

   int        checks_done;
   int        watchdog_cycles;
   logic      tests_loaded;

   move_gen_top #(
      .MAX_MOVES (128)
   ) u_move_gen_top (
      .clk              (clk),
      .reset            (reset),
      .board_valid      (board_valid),
      .board_in         (board_in),
      .white_to_move_in (white_to_move_in),
      .clear_moves      (clear_moves),
      .move_index       (move_index),
      .moves_ready      (moves_ready),
      .move_count       (move_count),
      .board_out        (board_out)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic fail_run(string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic load_tests();
      int     fd;
      int     n;
      int     side;
      int     cnt;
      int     idx;
      int     last;
      byte    tag;
      string  line;
      board_t bd;
      fd = $fopen("dv/move_gen_tests.txt", "r");
      if (fd == 0)
         fail_run("could not open dv/move_gen_tests.txt for reading");
      else
      begin
         while (!$feof(fd))
         begin
            line = "";
            n = $fgets(line, fd);
            tag = (n > 0) ? line.getc(0) : 8'h00;
            if (tag == "B")
            begin
               if ($sscanf(line, "B %h %d %d", bd, side, cnt) != 3)
                  fail_run({"malformed test line: ", line});
               test_board.push_back(bd);
               test_white.push_back(side != 0);
               test_count.push_back(move_idx_t'(cnt));
               test_first.push_back(pick_index.size());
               test_picks.push_back(0);
            end
            else if (tag == "M")
            begin
               if ($sscanf(line, "M %d %h", idx, bd) != 2 || test_board.size() == 0)
                  fail_run({"malformed or misplaced board line: ", line});
               pick_index.push_back(move_idx_t'(idx));
               pick_board.push_back(bd);
               last = test_picks.size() - 1;
               test_picks[last] = test_picks[last] + 1;
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic check_count(move_idx_t got, move_idx_t exp, int t);
      checks_done++;
      if (got !== exp)
         fail_run($sformatf("ERROR %0t: test %0d move count is %0d, expected %0d",
                            $time, t, got, exp));
   endtask

   task automatic check_board(board_t got, board_t exp, move_idx_t idx);
      checks_done++;
      if (got !== exp)
         fail_run($sformatf("ERROR %0t: board at index %0d is %h, expected %h",
                            $time, idx, got, exp));
   endtask

   task automatic check_ready(logic got, logic exp);
      checks_done++;
      if (got !== exp)
         fail_run($sformatf("ERROR %0t: moves_ready is %b, expected %b",
                            $time, got, exp));
   endtask

   task automatic load_position(board_t bd, logic white);
      @(posedge clk);
      board_valid <= 1'b1;
      board_in <= bd;
      white_to_move_in <= white;
      @(posedge clk);
      board_valid <= 1'b0;
   endtask

   task automatic wait_ready();
      @(negedge clk);
      while (moves_ready !== 1'b1)
         @(negedge clk);
   endtask

   task automatic read_board(move_idx_t idx, output board_t got);
      @(posedge clk);
      move_index <= idx;
      @(posedge clk); // registered read in the store
      @(negedge clk);
      got = board_out;
   endtask

   task automatic clear_results();
      @(posedge clk);
      clear_moves <= 1'b1;
      @(posedge clk);
      clear_moves <= 1'b0;
      @(negedge clk);
      check_ready(moves_ready, 1'b0); // back in idle one clock after the clear
   endtask

   task automatic run_test(int t);
      board_t got;
      int     k;
      int     p;
      load_position(test_board[t], test_white[t]);
      wait_ready();
      check_count(move_count, test_count[t], t);
      for (k = 0; k < test_picks[t]; k++)
      begin
         p = test_first[t] + k;
         read_board(pick_index[p], got);
         check_board(got, pick_board[p], pick_index[p]);
      end
      clear_results(); // next load starts from an empty store
   endtask

   initial
   begin
      wait (tests_loaded === 1'b1);
      repeat (watchdog_cycles) @(posedge clk);
      fail_run($sformatf("timeout after %0d clocks, the generator did not finish the tests",
                         watchdog_cycles));
   end

   initial
   begin
      int t;
      checks_done = 0;
      tests_loaded = 1'b0;
      reset = 1'b1;
      board_valid = 1'b0;
      board_in = '0;
      white_to_move_in = 1'b0;
      clear_moves = 1'b0;
      move_index = '0;
      load_tests();
      watchdog_cycles = 20 + 2000 * test_board.size();
      tests_loaded = 1'b1;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      for (t = 0; t < test_board.size(); t++)
         run_test(t);
      if (checks_done == 0)
         fail_run("no checks were run, the test file holds no tests");
      else
      begin
         $display("All checks passed");
         $finish;
      end
   end

endmodule

/* dv/move_gen_tests.txt */
# B <board as 64 hex digits, row 7 col 7 first, row 0 col 0 last> <white to move 1/0> <count>
# M <store index> <expected board at that index, same digit order>
B 0000000000000000000000000000000000000000000000000000000000000004 1 14
M 0 0000000000000000000000000000000000000000000000000000000000000040
M 13 0000000400000000000000000000000000000000000000000000000000000000
B A000000000000000000000000000000000000000000000000000000000000000 0 2
M 0 00000000000000000A0000000000000000000000000000000000000000000000
M 1 0000000000A00000000000000000000000000000000000000000000000000000
B 6100000011000000000000000000000000000000000000000000000000000000 1 0
B 000000000000000000000000000C000000000000000003000000001000000000 1 8
M 0 000000000000000000000000000C000000000000000003100000000000000000
M 3 0000000000000000000000000003000000000000000000000000001000000000
M 7 000000000000000000000000000C000000000000000000000000001000030000
B 0000000000000000000000000000000000000000000000000000100000000000 1 2
M 0 0000000000000000000000000000000000000000000010000000000000000000
M 1 0000000000000000000000000000000000001000000000000000000000000000
B 0000000000000000000000000000000000000000000A0A000000100000000000 1 4
M 2 0000000000000000000000000000000000000000000A01000000000000000000
M 3 000000000000000000000000000000000000000000010A000000000000000000
B 00000000000000000000000000000000000000000000A0000000100000000000 1 0
B 0000000000000100000000000000000000000000000000000000000000000000 1 1
M 0 0000050000000000000000000000000000000000000000000000000000000000
B 0000000000000000000000000000000000000000000000000090000004000000 0 2
M 0 000000000000000000000000000000000000000000000000000000000004D00000
M 1 000000000000000000000000000000000000000000000000000000000D000000

/* logic/chess_pkg.sv */
package chess_pkg;

   localparam int PIECE_BITS    = 4;
   localparam int KIND_BITS     = 3;
   localparam int BLACK_BIT     = 3;
   localparam int MOVE_IDX_BITS = 8;

   // one square, colour in the top bit
   typedef logic [PIECE_BITS-1:0] piece_t;

   // piece kind without the colour
   typedef logic [KIND_BITS-1:0] kind_t;

   // 64 squares, row major, row 0 is the white back rank
   typedef logic [64*PIECE_BITS-1:0] board_t;

   // row or column that may step off the board
   typedef logic signed [4:0] coord_t;

   // row or column offset, -2 .. +2
   typedef logic signed [2:0] step_t;

   typedef logic [3:0] dir_idx_t;

   // store address and move count
   typedef logic [MOVE_IDX_BITS-1:0] move_idx_t;

   localparam kind_t KIND_EMPTY  = 3'd0;
   localparam kind_t KIND_PAWN   = 3'd1;
   localparam kind_t KIND_KNIGHT = 3'd2;
   localparam kind_t KIND_BISHOP = 3'd3;
   localparam kind_t KIND_ROOK   = 3'd4;
   localparam kind_t KIND_QUEEN  = 3'd5;
   localparam kind_t KIND_KING   = 3'd6;

   typedef enum logic [2:0]
   {
      ST_IDLE,   // waiting for a board
      ST_CLEAR,  // zero the store count
      ST_SQUARE, // classify the origin square
      ST_DIR,    // first target of a direction
      ST_TARGET, // one candidate target per clock
      ST_NEXT,   // step to the next square
      ST_DONE    // moves ready, wait for clear
   } seq_state_t;

endpackage

/* logic/move_builder.sv */
`timescale 1ns/10ps

module move_builder (
   input  chess_pkg::board_t board,
   input  logic              white_to_move,
   input  chess_pkg::coord_t from_row,
   input  chess_pkg::coord_t from_col,
   input  chess_pkg::coord_t to_row,
   input  chess_pkg::coord_t to_col,
   output logic              on_board,
   output logic              to_empty,
   output logic              to_enemy,
   output chess_pkg::board_t result_board
);
   import chess_pkg::*;

   logic [7:0] from_base;
   logic [7:0] to_base;
   piece_t     mover;
   piece_t     target;
   piece_t     placed;
   coord_t     promote_row;
   logic       promote;

   // bit offset of a square, four bits per piece
   assign from_base = {from_row[2:0], from_col[2:0], 2'b00};
   assign to_base = {to_row[2:0], to_col[2:0], 2'b00};

   assign mover = board[from_base +: PIECE_BITS];
   assign target = board[to_base +: PIECE_BITS];

   // 0..7 only when the upper two bits are clear
   assign on_board = (to_row[4:3] == 2'b00) && (to_col[4:3] == 2'b00);

   // contents of the target square
   assign to_empty = (target[KIND_BITS-1:0] == KIND_EMPTY);
   assign to_enemy = (target[KIND_BITS-1:0] != KIND_EMPTY) &&
                     (target[BLACK_BIT] == white_to_move); // black piece when white moves

   assign promote_row = white_to_move ? 5'sd7 : 5'sd0;
   assign promote = (mover[KIND_BITS-1:0] == KIND_PAWN) && (to_row == promote_row);

   // queen only
   assign placed = promote ? {~white_to_move, KIND_QUEEN} : mover;

   always_comb
   begin
      result_board = board;
      result_board[from_base +: PIECE_BITS] = {1'b0, KIND_EMPTY};
      result_board[to_base +: PIECE_BITS] = placed;
   end

endmodule

/* logic/move_gen_top.sv */
`timescale 1ns/10ps

module move_gen_top #(
   parameter int MAX_MOVES = 128
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 board_valid,
   input  chess_pkg::board_t    board_in,
   input  logic                 white_to_move_in,
   input  logic                 clear_moves,
   input  chess_pkg::move_idx_t move_index,
   output logic                 moves_ready,
   output chess_pkg::move_idx_t move_count,
   output chess_pkg::board_t    board_out
);
   import chess_pkg::*;

   kind_t    kind;
   dir_idx_t dir_idx;
   dir_idx_t dir_count;
   step_t    step_row;
   step_t    step_col;
   board_t   board;
   board_t   result_board;
   coord_t   from_row;
   coord_t   from_col;
   coord_t   to_row;
   coord_t   to_col;
   logic     white_to_move;
   logic     on_board;
   logic     to_empty;
   logic     to_enemy;
   logic     store_clear;
   logic     store_write;

   move_sequencer u_move_sequencer (
      .clk              (clk),
      .reset            (reset),
      .board_valid      (board_valid),
      .board_in         (board_in),
      .white_to_move_in (white_to_move_in),
      .clear_moves      (clear_moves),
      .step_row         (step_row),
      .step_col         (step_col),
      .dir_count        (dir_count),
      .on_board         (on_board),
      .to_empty         (to_empty),
      .to_enemy         (to_enemy),
      .moves_ready      (moves_ready),
      .kind             (kind),
      .white_to_move    (white_to_move),
      .dir_idx          (dir_idx),
      .board            (board),
      .from_row         (from_row),
      .from_col         (from_col),
      .to_row           (to_row),
      .to_col           (to_col),
      .store_clear      (store_clear),
      .store_write      (store_write)
   );

   offset_table u_offset_table (
      .kind          (kind),
      .white_to_move (white_to_move),
      .dir_idx       (dir_idx),
      .step_row      (step_row),
      .step_col      (step_col),
      .dir_count     (dir_count)
   );

   move_builder u_move_builder (
      .board         (board),
      .white_to_move (white_to_move),
      .from_row      (from_row),
      .from_col      (from_col),
      .to_row        (to_row),
      .to_col        (to_col),
      .on_board      (on_board),
      .to_empty      (to_empty),
      .to_enemy      (to_enemy),
      .result_board  (result_board)
   );

   move_store #(
      .MAX_MOVES (MAX_MOVES)
   ) u_move_store (
      .clk          (clk),
      .store_clear  (store_clear),
      .store_write  (store_write),
      .result_board (result_board),
      .move_index   (move_index),
      .move_count   (move_count),
      .board_out    (board_out)
   );

endmodule

/* logic/move_sequencer.sv */
`timescale 1ns/10ps

module move_sequencer (
   input  logic                clk,
   input  logic                reset,
   input  logic                board_valid,
   input  chess_pkg::board_t   board_in,
   input  logic                white_to_move_in,
   input  logic                clear_moves,
   input  chess_pkg::step_t    step_row,
   input  chess_pkg::step_t    step_col,
   input  chess_pkg::dir_idx_t dir_count,
   input  logic                on_board,
   input  logic                to_empty,
   input  logic                to_enemy,
   output logic                moves_ready,
   output chess_pkg::kind_t    kind,
   output logic                white_to_move,
   output chess_pkg::dir_idx_t dir_idx,
   output chess_pkg::board_t   board,
   output chess_pkg::coord_t   from_row,
   output chess_pkg::coord_t   from_col,
   output chess_pkg::coord_t   to_row,
   output chess_pkg::coord_t   to_col,
   output logic                store_clear,
   output logic                store_write
);
   import chess_pkg::*;

   seq_state_t state;
   piece_t     sq_piece;
   coord_t     start_row;
   logic       is_slider;
   logic       adv1_clear;
   logic       write_ok;

   // origin square of the scan
   assign sq_piece = board[{from_row[2:0], from_col[2:0], 2'b00} +: PIECE_BITS];
   assign start_row = white_to_move ? 5'sd1 : 5'sd6;
   assign is_slider = (kind == KIND_BISHOP) || (kind == KIND_ROOK) || (kind == KIND_QUEEN);

   // pawn entries follow the table order: single, double, left, right
   always_comb
   begin
      write_ok = 1'b0;
      if (on_board && kind == KIND_PAWN)
      begin
         case (dir_idx)
            4'd0:    write_ok = to_empty;
            4'd1:    write_ok = to_empty && adv1_clear && (from_row == start_row);
            default: write_ok = to_enemy;
         endcase
      end
      else if (on_board)
         write_ok = to_empty || to_enemy;
   end

   assign store_write = (state == ST_TARGET) && write_ok;
   assign store_clear = reset || (state == ST_CLEAR); // count also zeroed in reset
   assign moves_ready = (state == ST_DONE);

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= ST_IDLE;
      else
      begin
         case (state)
            ST_IDLE:
            begin
               board <= board_in;
               white_to_move <= white_to_move_in;
               if (board_valid)
                  state <= ST_CLEAR;
            end
            ST_CLEAR:
            begin
               from_row <= '0;
               from_col <= '0;
               state <= ST_SQUARE;
            end
            ST_SQUARE:
            begin
               kind <= sq_piece[KIND_BITS-1:0];
               dir_idx <= '0;
               if (sq_piece[KIND_BITS-1:0] == KIND_EMPTY)
                  state <= ST_NEXT;
               else if (sq_piece[BLACK_BIT] == white_to_move) // other side
                  state <= ST_NEXT;
               else
                  state <= ST_DIR;
            end
            ST_DIR:
            begin
               to_row <= from_row + step_row;
               to_col <= from_col + step_col;
               if (dir_idx == dir_count)
                  state <= ST_NEXT;
               else
                  state <= ST_TARGET;
            end
            ST_TARGET:
            begin
               if (kind == KIND_PAWN && dir_idx == 4'd0)
                  adv1_clear <= on_board && to_empty;
               if (is_slider && on_board && to_empty)
               begin
                  to_row <= to_row + step_row; // keep walking the ray
                  to_col <= to_col + step_col;
               end
               else
               begin
                  dir_idx <= dir_idx + 4'd1;
                  state <= ST_DIR;
               end
            end
            ST_NEXT:
            begin
               if (from_col == 5'sd7)
               begin
                  from_col <= '0;
                  from_row <= from_row + 5'sd1;
               end
               else
                  from_col <= from_col + 5'sd1;
               if (from_row == 5'sd7 && from_col == 5'sd7)
                  state <= ST_DONE;
               else
                  state <= ST_SQUARE;
            end
            ST_DONE:
            begin
               if (clear_moves)
                  state <= ST_IDLE;
            end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

endmodule

/* logic/move_store.sv */
`timescale 1ns/10ps

module move_store #(
   parameter int MAX_MOVES = 128
) (
   input  logic                 clk,
   input  logic                 store_clear,
   input  logic                 store_write,
   input  chess_pkg::board_t    result_board,
   input  chess_pkg::move_idx_t move_index,
   output chess_pkg::move_idx_t move_count,
   output chess_pkg::board_t    board_out
);
   import chess_pkg::*;

   localparam int ADDR_BITS = $clog2(MAX_MOVES);
   localparam int CNT_BITS = MOVE_IDX_BITS + 1; // room for a count of 256

   board_t              ram [MAX_MOVES];
   logic [CNT_BITS-1:0] wr_count;
   logic                full;
   logic                wr_en;

   assign full = (wr_count == CNT_BITS'(MAX_MOVES));
   assign wr_en = store_write && !full; // drop writes past the depth

   always_ff @(posedge clk)
   begin
      if (store_clear)
         wr_count <= '0;
      else if (wr_en)
         wr_count <= wr_count + 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (wr_en)
         ram[wr_count[ADDR_BITS-1:0]] <= result_board;
      board_out <= ram[move_index[ADDR_BITS-1:0]];
   end

   assign move_count = wr_count[MOVE_IDX_BITS-1:0];

endmodule

/* logic/offset_table.sv */
`timescale 1ns/10ps

module offset_table (
   input  chess_pkg::kind_t    kind,
   input  logic                white_to_move,
   input  chess_pkg::dir_idx_t dir_idx,
   output chess_pkg::step_t    step_row,
   output chess_pkg::step_t    step_col,
   output chess_pkg::dir_idx_t dir_count
);
   import chess_pkg::*;

   localparam step_t ROOK_ROW [4]   = '{3'sd0, 3'sd0, 3'sd1, -3'sd1};
   localparam step_t ROOK_COL [4]   = '{3'sd1, -3'sd1, 3'sd0, 3'sd0};
   localparam step_t BISHOP_ROW [4] = '{3'sd1, 3'sd1, -3'sd1, -3'sd1};
   localparam step_t BISHOP_COL [4] = '{3'sd1, -3'sd1, 3'sd1, -3'sd1};

   // queen and king, row outer loop, centre skipped
   localparam step_t RING_ROW [8] =
      '{-3'sd1, -3'sd1, -3'sd1, 3'sd0, 3'sd0, 3'sd1, 3'sd1, 3'sd1};
   localparam step_t RING_COL [8] =
      '{-3'sd1, 3'sd0, 3'sd1, -3'sd1, 3'sd1, -3'sd1, 3'sd0, 3'sd1};

   localparam step_t KNIGHT_ROW [8] =
      '{-3'sd2, -3'sd1, 3'sd1, 3'sd2, 3'sd2, 3'sd1, -3'sd1, -3'sd2};
   localparam step_t KNIGHT_COL [8] =
      '{-3'sd1, -3'sd2, -3'sd2, -3'sd1, 3'sd1, 3'sd2, 3'sd2, 3'sd1};

   // white direction, negated for black
   localparam step_t PAWN_ROW [4] = '{3'sd1, 3'sd2, 3'sd1, 3'sd1};
   localparam step_t PAWN_COL [4] = '{3'sd0, 3'sd0, -3'sd1, 3'sd1};

   always_comb
   begin
      step_row = '0;
      step_col = '0;
      dir_count = '0;
      case (kind)
         KIND_ROOK:
         begin
            step_row = ROOK_ROW[dir_idx[1:0]];
            step_col = ROOK_COL[dir_idx[1:0]];
            dir_count = 4'd4;
         end
         KIND_BISHOP:
         begin
            step_row = BISHOP_ROW[dir_idx[1:0]];
            step_col = BISHOP_COL[dir_idx[1:0]];
            dir_count = 4'd4;
         end
         KIND_QUEEN, KIND_KING:
         begin
            step_row = RING_ROW[dir_idx[2:0]];
            step_col = RING_COL[dir_idx[2:0]];
            dir_count = 4'd8;
         end
         KIND_KNIGHT:
         begin
            step_row = KNIGHT_ROW[dir_idx[2:0]];
            step_col = KNIGHT_COL[dir_idx[2:0]];
            dir_count = 4'd8;
         end
         KIND_PAWN:
         begin
            step_row = white_to_move ? PAWN_ROW[dir_idx[1:0]] : -PAWN_ROW[dir_idx[1:0]];
            step_col = PAWN_COL[dir_idx[1:0]];
            dir_count = 4'd4;
         end
         default:
            dir_count = '0; // empty or unused code
      endcase
   end

endmodule

/* move_gen_top.f */
logic/chess_pkg.sv
logic/offset_table.sv
logic/move_builder.sv
logic/move_store.sv
logic/move_sequencer.sv
logic/move_gen_top.sv
dv/move_gen_assert.sv
dv/move_gen_tb.sv
